// File: common/decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_if;

  logic                            valid;
  logic [rv32i_pkg::XLEN-1:0]      pc;
  logic [rv32i_pkg::REG_BITS-1:0]  rs1_addr;
  logic [rv32i_pkg::REG_BITS-1:0]  rs2_addr;
  logic [rv32i_pkg::REG_BITS-1:0]  rd_addr;
  rv32i_pkg::alu_op_t              alu_op;
  logic                            use_imm;     // Operand B from imm
  logic [rv32i_pkg::XLEN-1:0]      imm;         // JAL target for jumps
  rv32i_pkg::wb_sel_t              wb_sel;
  logic                            branch;
  logic [2:0]                      branch_cond; // funct3 of the branch
  logic                            jal;
  logic                            jalr;

  // Execute takes one item per cycle, hence no ready
  modport decode (
    output valid, pc, rs1_addr, rs2_addr, rd_addr, alu_op, use_imm, imm,
    output wb_sel, branch, branch_cond, jal, jalr
  );

  modport execute (
    input  valid, pc, rs1_addr, rs2_addr, rd_addr, alu_op, use_imm, imm,
    input  wb_sel, branch, branch_cond, jal, jalr
  );

endinterface

`default_nettype wire

// File: common/fetch_if.sv
`timescale 1ns/1ps
`default_nettype none

// One fetched word on its way to decode
interface fetch_if;

  logic                          valid;
  logic                          ready;
  rv32i_pkg::instr_u             instr;
  logic [rv32i_pkg::XLEN-1:0]    pc;    // Address the word came from

  modport fetch (
    output valid, instr, pc,
    input  ready
  );

  modport decode (
    input  valid, instr, pc,
    output ready
  );

endinterface

`default_nettype wire

// File: common/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

  localparam int XLEN     = 32;
  localparam int REG_BITS = 5;

  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  // Opcode bits 6..2, low two bits are always 2'b11
  localparam logic [4:0] OP_LOAD   = 5'b00000;
  localparam logic [4:0] OP_FENCE  = 5'b00011;
  localparam logic [4:0] OP_OP_IMM = 5'b00100;
  localparam logic [4:0] OP_AUIPC  = 5'b00101;
  localparam logic [4:0] OP_STORE  = 5'b01000;
  localparam logic [4:0] OP_OP     = 5'b01100;
  localparam logic [4:0] OP_LUI    = 5'b01101;
  localparam logic [4:0] OP_BRANCH = 5'b11000;
  localparam logic [4:0] OP_JALR   = 5'b11001;
  localparam logic [4:0] OP_JAL    = 5'b11011;
  localparam logic [4:0] OP_SYSTEM = 5'b11100;

  // Instruction formats seen by decode
  localparam logic [2:0] FMT_NONE = 3'd0;
  localparam logic [2:0] FMT_R    = 3'd1;
  localparam logic [2:0] FMT_I    = 3'd2;
  localparam logic [2:0] FMT_S    = 3'd3;
  localparam logic [2:0] FMT_U    = 3'd4;
  localparam logic [2:0] FMT_B    = 3'd5;
  localparam logic [2:0] FMT_J    = 3'd6;

  // Fetch FSM states
  localparam logic [1:0] FETCH_IDLE = 2'd0;
  localparam logic [1:0] FETCH_REQ  = 2'd1;
  localparam logic [1:0] FETCH_HOLD = 2'd2;

  // Code is {funct7[5], funct3}, PASS_B sits in an unused slot
  typedef enum logic [3:0] {
    ALU_ADD    = 4'b0000,
    ALU_SLL    = 4'b0001,
    ALU_SLT    = 4'b0010,
    ALU_SLTU   = 4'b0011,
    ALU_XOR    = 4'b0100,
    ALU_SRL    = 4'b0101,
    ALU_OR     = 4'b0110,
    ALU_AND    = 4'b0111,
    ALU_SUB    = 4'b1000,
    ALU_SRA    = 4'b1101,
    ALU_PASS_B = 4'b1111
  } alu_op_t;

  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_IMM  = 2'd1,
    WB_LINK = 2'd2, // PC+4
    WB_NONE = 2'd3
  } wb_sel_t;

  typedef union packed {
    struct packed {
      logic [6:0]          funct7;
      logic [REG_BITS-1:0] rs2;
      logic [REG_BITS-1:0] rs1;
      logic [2:0]          funct3;
      logic [REG_BITS-1:0] rd;
      logic [6:0]          opcode;
    } r;
    struct packed {
      logic [11:0]         imm12;
      logic [REG_BITS-1:0] rs1;
      logic [2:0]          funct3;
      logic [REG_BITS-1:0] rd;
      logic [6:0]          opcode;
    } i;
  } instr_u;

endpackage

`default_nettype wire

// File: decode/rv32i_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_decode (
  input  logic      clk_i,
  input  logic      rst_n_i,
  fetch_if.decode   fetch_i,
  decode_if.decode  dec_o,
  input  logic      redirect_valid_i
);

  rv32i_pkg::instr_u          instr;
  logic [31:0]                raw;
  logic [4:0]                 opcode;
  logic [2:0]                 funct3;
  logic [2:0]                 fmt;
  logic                       load;
  logic [rv32i_pkg::XLEN-1:0] imm_i;
  logic [rv32i_pkg::XLEN-1:0] imm_s;
  logic [rv32i_pkg::XLEN-1:0] imm_b;
  logic [rv32i_pkg::XLEN-1:0] imm_u;
  logic [rv32i_pkg::XLEN-1:0] imm_j;

  assign fetch_i.ready = 1'b1; // Execute never stalls

  assign instr  = fetch_i.instr;
  assign raw    = fetch_i.instr;
  assign opcode = instr.r.opcode[6:2];
  assign funct3 = instr.r.funct3;
  assign load   = fetch_i.valid & fetch_i.ready;

  // Sign-extended immediates of every format
  assign imm_i = {{20{instr.i.imm12[11]}}, instr.i.imm12};
  assign imm_s = {{20{raw[31]}}, raw[31:25], raw[11:7]};
  assign imm_b = {{20{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
  assign imm_u = {raw[31:12], 12'b0};
  assign imm_j = {{12{raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};

  always_comb
  begin
    case (opcode)
      rv32i_pkg::OP_OP:                       fmt = rv32i_pkg::FMT_R;
      rv32i_pkg::OP_OP_IMM, rv32i_pkg::OP_JALR: fmt = rv32i_pkg::FMT_I;
      rv32i_pkg::OP_STORE:                    fmt = rv32i_pkg::FMT_S;
      rv32i_pkg::OP_LUI, rv32i_pkg::OP_AUIPC: fmt = rv32i_pkg::FMT_U;
      rv32i_pkg::OP_BRANCH:                   fmt = rv32i_pkg::FMT_B;
      rv32i_pkg::OP_JAL:                      fmt = rv32i_pkg::FMT_J;
      // Not implemented, these retire as no-ops
      rv32i_pkg::OP_LOAD, rv32i_pkg::OP_FENCE, rv32i_pkg::OP_SYSTEM:
        fmt = rv32i_pkg::FMT_NONE;
      default:                                fmt = rv32i_pkg::FMT_NONE;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      dec_o.valid <= 1'b0;
    else if (redirect_valid_i)
      dec_o.valid <= 1'b0; // Wrong-path word
    else
      dec_o.valid <= load;
  end

  always_ff @(posedge clk_i)
  begin
    if (load)
    begin
      dec_o.pc          <= fetch_i.pc;
      dec_o.rs1_addr    <= '0;
      dec_o.rs2_addr    <= '0;
      dec_o.rd_addr     <= '0;
      dec_o.alu_op      <= rv32i_pkg::ALU_ADD;
      dec_o.use_imm     <= 1'b0;
      dec_o.imm         <= '0;
      dec_o.wb_sel      <= rv32i_pkg::WB_NONE;
      dec_o.branch      <= 1'b0;
      dec_o.branch_cond <= funct3;
      dec_o.jal         <= 1'b0;
      dec_o.jalr        <= 1'b0;
      case (fmt)
        rv32i_pkg::FMT_R:
        begin
          dec_o.rs1_addr <= instr.r.rs1;
          dec_o.rs2_addr <= instr.r.rs2;
          dec_o.rd_addr  <= instr.r.rd;
          dec_o.alu_op   <= rv32i_pkg::alu_op_t'({instr.r.funct7[5], funct3});
          dec_o.wb_sel   <= rv32i_pkg::WB_ALU;
        end
        rv32i_pkg::FMT_I:
        begin
          dec_o.rs1_addr <= instr.r.rs1;
          dec_o.rd_addr  <= instr.r.rd;
          dec_o.use_imm  <= 1'b1;
          dec_o.imm      <= imm_i;
          if (opcode == rv32i_pkg::OP_JALR)
          begin
            dec_o.jalr   <= 1'b1; // ALU adds rs1 and imm for the target
            dec_o.wb_sel <= rv32i_pkg::WB_LINK;
          end
          else
          begin
            // Only SRAI takes funct7[5] from the immediate
            if (funct3 == 3'b101)
              dec_o.alu_op <= rv32i_pkg::alu_op_t'({instr.r.funct7[5], funct3});
            else
              dec_o.alu_op <= rv32i_pkg::alu_op_t'({1'b0, funct3});
            dec_o.wb_sel <= rv32i_pkg::WB_ALU;
          end
        end
        rv32i_pkg::FMT_S:
        begin
          dec_o.rs1_addr <= instr.r.rs1;
          dec_o.rs2_addr <= instr.r.rs2;
          dec_o.imm      <= imm_s;
        end
        rv32i_pkg::FMT_U:
        begin
          dec_o.rd_addr <= instr.r.rd;
          dec_o.alu_op  <= rv32i_pkg::ALU_PASS_B;
          dec_o.use_imm <= 1'b1;
          dec_o.wb_sel  <= rv32i_pkg::WB_IMM;
          if (opcode == rv32i_pkg::OP_AUIPC)
            dec_o.imm <= fetch_i.pc + imm_u;
          else
            dec_o.imm <= imm_u;
        end
        rv32i_pkg::FMT_B:
        begin
          dec_o.rs1_addr <= instr.r.rs1;
          dec_o.rs2_addr <= instr.r.rs2;
          dec_o.imm      <= imm_b;
          dec_o.branch   <= 1'b1;
        end
        rv32i_pkg::FMT_J:
        begin
          dec_o.rd_addr <= instr.r.rd;
          dec_o.jal     <= 1'b1;
          dec_o.imm     <= fetch_i.pc + imm_j; // Jump target
          dec_o.wb_sel  <= rv32i_pkg::WB_LINK;
        end
        default:
        begin
          dec_o.wb_sel <= rv32i_pkg::WB_NONE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: execute/rv32i_execute.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_execute (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  decode_if.execute                      dec_i,
  output logic                           redirect_valid_o,
  output logic [rv32i_pkg::XLEN-1:0]     redirect_pc_o,
  output logic                           retire_valid_o,
  output logic [rv32i_pkg::XLEN-1:0]     retire_pc_o,
  output logic [rv32i_pkg::REG_BITS-1:0] retire_rd_o,
  output logic [rv32i_pkg::XLEN-1:0]     retire_data_o
);

  logic [rv32i_pkg::XLEN-1:0] rs1_data;
  logic [rv32i_pkg::XLEN-1:0] rs2_data;
  logic [rv32i_pkg::XLEN-1:0] op_b;
  logic [rv32i_pkg::XLEN-1:0] alu_res;
  logic [rv32i_pkg::XLEN-1:0] link;
  logic [rv32i_pkg::XLEN-1:0] target;
  logic [rv32i_pkg::XLEN-1:0] wb_data;
  logic                       accept;
  logic                       cond_met;
  logic                       taken;
  logic                       we;

  rv32i_regfile rv32i_regfile_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rs1_addr_i (dec_i.rs1_addr),
    .rs2_addr_i (dec_i.rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (we),
    .rd_addr_i  (dec_i.rd_addr),
    .rd_data_i  (wb_data)
  );

  // Item behind a taken transfer is on the wrong path
  assign accept = dec_i.valid & ~redirect_valid_o;
  assign op_b   = dec_i.use_imm ? dec_i.imm : rs2_data;
  assign link   = dec_i.pc + 32'd4;

  always_comb
  begin
    case (dec_i.alu_op)
      rv32i_pkg::ALU_ADD:    alu_res = rs1_data + op_b;
      rv32i_pkg::ALU_SUB:    alu_res = rs1_data - op_b;
      rv32i_pkg::ALU_SLL:    alu_res = rs1_data << op_b[4:0];
      rv32i_pkg::ALU_SLT:    alu_res = {31'b0, $signed(rs1_data) < $signed(op_b)};
      rv32i_pkg::ALU_SLTU:   alu_res = {31'b0, rs1_data < op_b};
      rv32i_pkg::ALU_XOR:    alu_res = rs1_data ^ op_b;
      rv32i_pkg::ALU_SRL:    alu_res = rs1_data >> op_b[4:0];
      rv32i_pkg::ALU_SRA:    alu_res = $signed(rs1_data) >>> op_b[4:0];
      rv32i_pkg::ALU_OR:     alu_res = rs1_data | op_b;
      rv32i_pkg::ALU_AND:    alu_res = rs1_data & op_b;
      rv32i_pkg::ALU_PASS_B: alu_res = op_b;
      default:               alu_res = '0;
    endcase
  end

  always_comb
  begin
    case (dec_i.branch_cond)
      3'b000:  cond_met = (rs1_data == rs2_data);                   // beq
      3'b001:  cond_met = (rs1_data != rs2_data);                   // bne
      3'b100:  cond_met = ($signed(rs1_data) < $signed(rs2_data));  // blt
      3'b101:  cond_met = ($signed(rs1_data) >= $signed(rs2_data)); // bge
      3'b110:  cond_met = (rs1_data < rs2_data);                    // bltu
      3'b111:  cond_met = (rs1_data >= rs2_data);                   // bgeu
      default: cond_met = 1'b0;
    endcase
  end

  always_comb
  begin
    if (dec_i.jalr)
      target = {alu_res[31:1], 1'b0};
    else if (dec_i.jal)
      target = dec_i.imm; // Computed in decode
    else
      target = dec_i.pc + dec_i.imm;
  end

  assign taken = dec_i.jal | dec_i.jalr | (dec_i.branch & cond_met);

  always_comb
  begin
    case (dec_i.wb_sel)
      rv32i_pkg::WB_ALU:  wb_data = alu_res;
      rv32i_pkg::WB_IMM:  wb_data = dec_i.imm;
      rv32i_pkg::WB_LINK: wb_data = link;
      default:            wb_data = '0;
    endcase
  end

  assign we = accept & (dec_i.wb_sel != rv32i_pkg::WB_NONE) & (dec_i.rd_addr != '0);

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      retire_valid_o   <= 1'b0;
      redirect_valid_o <= 1'b0;
    end
    else
    begin
      retire_valid_o   <= accept;
      redirect_valid_o <= accept & taken;
    end
  end

  always_ff @(posedge clk_i)
  begin
    retire_pc_o   <= dec_i.pc;
    retire_rd_o   <= we ? dec_i.rd_addr : '0;
    retire_data_o <= we ? wb_data : '0;
    redirect_pc_o <= target;
  end

endmodule

`default_nettype wire

// File: fetch/rv32i_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_fetch (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  fetch_if.fetch                     fetch_o,
  input  logic                       redirect_valid_i,
  input  logic [rv32i_pkg::XLEN-1:0] redirect_pc_i,
  output logic                       ibus_cyc_o,
  output logic                       ibus_stb_o,
  output logic [rv32i_pkg::XLEN-1:0] ibus_adr_o,
  input  logic [rv32i_pkg::XLEN-1:0] ibus_dat_i,
  input  logic                       ibus_ack_i
);

  logic [1:0]                 state_q;
  logic [rv32i_pkg::XLEN-1:0] pc_q;       // Open request or held word
  logic [rv32i_pkg::XLEN-1:0] redir_pc_q; // Target seen during an open request
  logic                       stale_q;
  rv32i_pkg::instr_u          instr_q;

  assign ibus_cyc_o = (state_q == rv32i_pkg::FETCH_REQ);
  assign ibus_stb_o = (state_q == rv32i_pkg::FETCH_REQ);
  assign ibus_adr_o = pc_q;

  assign fetch_o.valid = (state_q == rv32i_pkg::FETCH_HOLD);
  assign fetch_o.instr = instr_q;
  assign fetch_o.pc    = pc_q;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q <= rv32i_pkg::FETCH_IDLE;
      pc_q    <= rv32i_pkg::RESET_PC;
      stale_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        rv32i_pkg::FETCH_REQ:
        begin
          if (ibus_ack_i)
          begin
            stale_q <= 1'b0;
            if (redirect_valid_i)
              pc_q <= redirect_pc_i; // Word dropped, refetch at once
            else if (stale_q)
              pc_q <= redir_pc_q;
            else
              state_q <= rv32i_pkg::FETCH_HOLD;
          end
          else if (redirect_valid_i)
            stale_q <= 1'b1; // Request stays open until ack
        end
        rv32i_pkg::FETCH_HOLD:
        begin
          if (redirect_valid_i)
          begin
            pc_q    <= redirect_pc_i;
            state_q <= rv32i_pkg::FETCH_REQ;
          end
          else if (fetch_o.ready)
          begin
            pc_q    <= pc_q + 32'd4;
            state_q <= rv32i_pkg::FETCH_REQ;
          end
        end
        default:
        begin
          if (redirect_valid_i)
            pc_q <= redirect_pc_i;
          state_q <= rv32i_pkg::FETCH_REQ;
        end
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (ibus_cyc_o && ibus_ack_i)
      instr_q <= ibus_dat_i;
    if (ibus_cyc_o && redirect_valid_i)
      redir_pc_q <= redirect_pc_i; // Latest redirect wins
  end

endmodule

`default_nettype wire

// File: files.f
common/rv32i_pkg.sv
common/fetch_if.sv
common/decode_if.sv
hdl/rv32i_regfile.sv
fetch/rv32i_fetch.sv
decode/rv32i_decode.sv
execute/rv32i_execute.sv
hdl/rv32i_core.sv
sim/tb_rv32i_core.sv

// File: hdl/rv32i_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_core (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  output logic                           ibus_cyc_o,
  output logic                           ibus_stb_o,
  output logic [rv32i_pkg::XLEN-1:0]     ibus_adr_o,
  input  logic [rv32i_pkg::XLEN-1:0]     ibus_dat_i,
  input  logic                           ibus_ack_i,
  output logic                           retire_valid_o,
  output logic [rv32i_pkg::XLEN-1:0]     retire_pc_o,
  output logic [rv32i_pkg::REG_BITS-1:0] retire_rd_o,
  output logic [rv32i_pkg::XLEN-1:0]     retire_data_o
);

  fetch_if  fetch_bus ();
  decode_if dec_bus ();

  logic                       redirect_valid;
  logic [rv32i_pkg::XLEN-1:0] redirect_pc;

  rv32i_fetch rv32i_fetch_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .fetch_o          (fetch_bus.fetch),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .ibus_cyc_o       (ibus_cyc_o),
    .ibus_stb_o       (ibus_stb_o),
    .ibus_adr_o       (ibus_adr_o),
    .ibus_dat_i       (ibus_dat_i),
    .ibus_ack_i       (ibus_ack_i)
  );

  rv32i_decode rv32i_decode_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .fetch_i          (fetch_bus.decode),
    .dec_o            (dec_bus.decode),
    .redirect_valid_i (redirect_valid)
  );

  // Register file lives inside execute
  rv32i_execute rv32i_execute_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .dec_i            (dec_bus.execute),
    .redirect_valid_o (redirect_valid),
    .redirect_pc_o    (redirect_pc),
    .retire_valid_o   (retire_valid_o),
    .retire_pc_o      (retire_pc_o),
    .retire_rd_o      (retire_rd_o),
    .retire_data_o    (retire_data_o)
  );

endmodule

`default_nettype wire

// File: hdl/rv32i_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module rv32i_regfile (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic [rv32i_pkg::REG_BITS-1:0] rs1_addr_i,
  input  logic [rv32i_pkg::REG_BITS-1:0] rs2_addr_i,
  output logic [rv32i_pkg::XLEN-1:0]     rs1_data_o,
  output logic [rv32i_pkg::XLEN-1:0]     rs2_data_o,
  input  logic                           we_i,
  input  logic [rv32i_pkg::REG_BITS-1:0] rd_addr_i,
  input  logic [rv32i_pkg::XLEN-1:0]     rd_data_i
);

  logic [rv32i_pkg::XLEN-1:0] regs_q [1:31]; // x0 has no storage

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      for (int i = 1; i < 32; i++)
        regs_q[i] <= '0;
    end
    else if (we_i && (rd_addr_i != '0))
      regs_q[rd_addr_i] <= rd_data_i;
  end

  // Combinational reads
  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_rv32i_core -f files.f
# The log decides the result, so a nonzero exit here is not fatal
./obj_dir/Vtb_rv32i_core > sim.log 2>&1 || true
cat sim.log
if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
  exit 1
fi
exit 0

// File: sim/tb_rv32i_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv32i_core;

  localparam int          MEM_WORDS   = 256;
  localparam int          MAX_EXP     = 64;
  localparam int          MAX_TESTS   = 8;
  localparam int          WAIT_CYCLES = 100;
  localparam logic [31:0] BOOT_PC     = 32'h0000_0000;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic        ibus_cyc_o;
  logic        ibus_stb_o;
  logic [31:0] ibus_adr_o;
  logic [31:0] ibus_dat_i;
  logic        ibus_ack_i;
  logic        retire_valid_o;
  logic [31:0] retire_pc_o;
  logic [4:0]  retire_rd_o;
  logic [31:0] retire_data_o;

  logic [31:0] mem      [0:MEM_WORDS-1];
  logic [31:0] exp_pc   [0:MAX_EXP-1];
  logic [31:0] exp_rd   [0:MAX_EXP-1];
  logic [31:0] exp_data [0:MAX_EXP-1];
  int          exp_test [0:MAX_EXP-1]; // Index into test_name
  string       test_name [0:MAX_TESTS-1];
  int          exp_count;
  int          test_count;
  int          tests_done;
  int          checks;
  int          errors;
  int          test_checks;
  int          test_errors;
  logic        timed_out;

  // Bus slave state
  integer      seed = 66524;
  logic        busy;
  int          wait_left;
  logic [31:0] req_adr;
  int          bus_errors;

  rv32i_core rv32i_core_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .ibus_cyc_o     (ibus_cyc_o),
    .ibus_stb_o     (ibus_stb_o),
    .ibus_adr_o     (ibus_adr_o),
    .ibus_dat_i     (ibus_dat_i),
    .ibus_ack_i     (ibus_ack_i),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o)
  );

  always #10 clk_i = ~clk_i;

  // Wishbone classic slave with 0 to 3 wait states per request
  initial
  begin
    ibus_ack_i = 1'b0;
    ibus_dat_i = '0;
    busy       = 1'b0;
    wait_left  = 0;
    req_adr    = '0;
    bus_errors = 0;
    forever
    begin
      @(posedge clk_i);
      #1;
      if (ibus_ack_i)
      begin
        ibus_ack_i = 1'b0; // Transfer completed on this edge
        busy       = 1'b0;
      end
      else if (ibus_cyc_o && ibus_stb_o)
      begin
        if (!busy)
        begin
          busy      = 1'b1;
          req_adr   = ibus_adr_o;
          wait_left = $unsigned($random(seed)) % 4;
        end
        assert (ibus_adr_o == req_adr)
        else
        begin
          $display("Instruction address changed while a bus request was open");
          bus_errors++;
        end
        if (wait_left == 0)
        begin
          ibus_dat_i = mem[ibus_adr_o[9:2]];
          ibus_ack_i = 1'b1;
        end
        else
          wait_left--;
      end
      else
      begin
        assert (!ibus_cyc_o && !ibus_stb_o && !busy)
        else
        begin
          $display("Bus cycle and strobe disagree or a request ended without ack");
          bus_errors++;
        end
      end
    end
  end

  task automatic fill_memory();
    for (int i = 0; i < MEM_WORDS; i++)
      mem[i] = 32'hA5A5_0000 ^ (i << 2); // Filler only the wrong path fetches
  endtask

  task automatic load_testdata();
    integer           fd;
    integer           n;
    logic [8*16-1:0]  tag;
    logic [8*24-1:0]  name;
    logic [8*120-1:0] rest;
    logic [31:0]      f1;
    logic [31:0]      f2;
    logic [31:0]      f3;
    string            tag_s;
    fd = $fopen("sim/testdata_core.txt", "r");
    if (fd == 0)
      $display("Could not open the test data file");
    else
    begin
      while (!$feof(fd))
      begin
        tag = '0;
        n = $fscanf(fd, "%s", tag);
        tag_s = string'(tag);
        if (n == 1)
        begin
          if (tag_s == "#")
            n = $fgets(rest, fd);
          else if (tag_s == "T")
          begin
            name = '0;
            n = $fscanf(fd, "%s", name);
            test_name[test_count] = string'(name);
            test_count++;
          end
          else if (tag_s == "P")
          begin
            n = $fscanf(fd, "%h %h", f1, f2);
            mem[f1[9:2]] = f2;
          end
          else if (tag_s == "E")
          begin
            n = $fscanf(fd, "%h %h %h", f1, f2, f3);
            exp_pc[exp_count]   = f1;
            exp_rd[exp_count]   = f2;
            exp_data[exp_count] = f3;
            exp_test[exp_count] = test_count - 1;
            exp_count++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic compare_value(input string sig, input logic [31:0] expected,
                               input logic [31:0] actual);
    test_checks++;
    assert (actual == expected)
    else
    begin
      $display("ERROR %s expected 0x%08h actual 0x%08h", sig, expected, actual);
      test_errors++;
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
    tests_done++;
    checks      = checks + test_checks;
    errors      = errors + test_errors;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic reset_sequence();
    int cycles;
    repeat (2)
    begin
      @(posedge clk_i);
      #1;
      test_checks++;
      assert (!ibus_cyc_o && !ibus_stb_o && !retire_valid_o)
      else
      begin
        $display("Bus cycle, strobe or retire seen while reset was asserted");
        test_errors++;
      end
    end
    rst_n_i = 1'b1;
    cycles = 0;
    do
    begin
      @(negedge clk_i);
      cycles++;
    end
    while (!ibus_cyc_o && cycles < WAIT_CYCLES);
    if (!ibus_cyc_o)
    begin
      $display("Timed out waiting for the first bus request");
      timed_out = 1'b1;
    end
    else
    begin
      compare_value("ibus_adr_o", BOOT_PC, ibus_adr_o);
      report_test("reset");
    end
  endtask

  // Walks the expected retire list one retire at a time
  task automatic follow_trace();
    int idx;
    int cycles;
    idx = 0;
    while (idx < exp_count && !timed_out)
    begin
      cycles = 0;
      do
      begin
        @(negedge clk_i);
        cycles++;
      end
      while (!retire_valid_o && cycles < WAIT_CYCLES);
      if (!retire_valid_o)
      begin
        $display("Timed out waiting for retire %0d of test %s", idx,
                 test_name[exp_test[idx]]);
        timed_out = 1'b1;
      end
      else
      begin
        compare_value("retire_pc_o", exp_pc[idx], retire_pc_o);
        compare_value("retire_rd_o", exp_rd[idx], {27'b0, retire_rd_o});
        compare_value("retire_data_o", exp_data[idx], retire_data_o);
        if (idx == exp_count - 1 || exp_test[idx + 1] != exp_test[idx])
          report_test(test_name[exp_test[idx]]); // Last retire of this test
        idx++;
      end
    end
  endtask

  initial
  begin
    rst_n_i     = 1'b0;
    exp_count   = 0;
    test_count  = 0;
    tests_done  = 0;
    checks      = 0;
    errors      = 0;
    test_checks = 0;
    test_errors = 0;
    timed_out   = 1'b0;
    fill_memory();
    load_testdata();
    reset_sequence();
    if (!timed_out)
      follow_trace();
    errors = errors + bus_errors;
    $display("tests %0d, checks %0d, errors %0d", tests_done, checks, errors);
    if (errors == 0 && !timed_out && exp_count > 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/testdata_core.txt
# P <addr> <word> is a program word, T <name> starts a test
# E <pc> <rd> <data> is one expected retire in order, all values in hex
P 00000000 ffb00093
P 00000004 00300113
P 00000008 401101b3
P 0000000c 4020d233
P 00000010 0020a2b3
P 00000014 0020b333
P 00000018 4010d393
P 0000001c 0f00c413
P 00000020 00208033
P 00000024 002064b3
P 00000028 12345537
P 0000002c 00001597
P 00000030 00208463
P 00000034 00209463
P 0000003c 0020c463
P 00000044 0020d463
P 00000048 0020e463
P 0000004c 0020f463
P 00000054 00248463
P 0000005c 00249463
P 00000060 00114463
P 00000064 00115463
P 0000006c 00116463
P 00000074 00117463
P 00000078 00c0066f
P 00000084 09100693
P 00000088 00468767
P 00000094 0000006f
T alu
E 00000000 01 fffffffb
E 00000004 02 00000003
E 00000008 03 00000008
E 0000000c 04 ffffffff
E 00000010 05 00000001
E 00000014 06 00000000
E 00000018 07 fffffffd
E 0000001c 08 ffffff0b
E 00000020 00 00000000
E 00000024 09 00000003
T upper
E 00000028 0a 12345000
E 0000002c 0b 0000102c
T branch
E 00000030 00 00000000
E 00000034 00 00000000
E 0000003c 00 00000000
E 00000044 00 00000000
E 00000048 00 00000000
E 0000004c 00 00000000
E 00000054 00 00000000
E 0000005c 00 00000000
E 00000060 00 00000000
E 00000064 00 00000000
E 0000006c 00 00000000
E 00000074 00 00000000
T jump
E 00000078 0c 0000007c
E 00000084 0d 00000091
E 00000088 0e 0000008c
E 00000094 00 00000000
E 00000094 00 00000000
